// File: include/teleport_settings.svh
/* build-time constants for the teleport drawing core
   framebuffer size is fixed at elaboration, coordinates are signed */
`ifndef TELEPORT_SETTINGS_SVH
`define TELEPORT_SETTINGS_SVH

// coordinate width, signed so shapes can start off-screen
`define TP_CORDW 16

// framebuffer geometry in pixels
`define TP_FB_WIDTH 640
`define TP_FB_HEIGHT 360

// colour index width, 16 palette entries
`define TP_CIDXW 4

// animation steps per colour turn
`define TP_ANIM_CNT 5

// frames shown per animation step
`define TP_ANIM_SPEED 4

// nested rectangles drawn per pass
`define TP_SHAPE_CNT 7

`endif

// File: logic/anim_ctrl.sv
/* frame counter for the animation, every frame pulse counts
   step advances every TP_ANIM_SPEED frames, offset on step wrap */
`timescale 1ns/1ps
`include "teleport_settings.svh"

module anim_ctrl (
    input  logic clk_100m,
    input  logic rst_n,
    input  logic frame,                         // one-cycle strobe
    output anim_pkg::anim_step_t anim_step,
    output gfx_types_pkg::cidx_t colr_offs
);
    import anim_pkg::*;

    anim_speed_t speed_cnt; // frames within current step

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            speed_cnt <= '0;
            anim_step <= '0;
            colr_offs <= '0;
        end else if (frame) begin
            if (speed_cnt == `TP_ANIM_SPEED - 1) begin
                speed_cnt <= '0;
                if (anim_step == `TP_ANIM_CNT - 1) begin
                    anim_step <= '0;
                    colr_offs <= colr_offs + 1'b1; // rotate palette, wraps at 16
                end else begin
                    anim_step <= anim_step + 1'b1;
                end
            end else begin
                speed_cnt <= speed_cnt + 1'b1;
            end
        end
    end

    // step field is wider than the count, values 5..7 must stay unused
    a_step_range: assert property (
        @(posedge clk_100m) disable iff (!rst_n)
        anim_step < `TP_ANIM_CNT
    ) else $error("anim_step out of range");

    // offset only moves on the frame that wraps the step
    a_offs_on_wrap: assert property (
        @(posedge clk_100m) disable iff (!rst_n)
        (colr_offs != $past(colr_offs)) |-> ($past(frame) && anim_step == '0)
    ) else $error("colour offset moved without step wrap");

endmodule

// File: logic/anim_pkg.sv
/* animation types and the fixed shape table
   the table holds seven shapes, ids 7..15 give a small fallback square */
`include "teleport_settings.svh"

package anim_pkg;

    typedef logic [$clog2(`TP_ANIM_CNT)-1:0] anim_step_t;   // animation step
    typedef logic [$clog2(`TP_ANIM_SPEED)-1:0] anim_speed_t; // frames within a step
    typedef logic [3:0] shape_id_t;

    // per-frame scheduler FSM
    typedef enum logic [1:0] {
        IDLE, // wait for frame
        INIT, // compute corners, launch filler
        DRAW, // wait for filler done
        DONE  // pass finished
    } sched_state_t;

    // base rectangle at step 0 plus growth per step
    typedef struct packed {
        gfx_types_pkg::coord_t bx0;
        gfx_types_pkg::coord_t by0;
        gfx_types_pkg::coord_t bx1;
        gfx_types_pkg::coord_t by1;
        gfx_types_pkg::coord_t rate;
    } shape_geom_t;

    function automatic shape_geom_t shape_geom(shape_id_t id);
        case (id)
            4'd0: return '{bx0:  80, by0:   0, bx1: 558, by1: 498, rate: 24};
            4'd1: return '{bx0: 160, by0:  20, bx1: 478, by1: 338, rate: 16};
            4'd2: return '{bx0: 210, by0:  70, bx1: 428, by1: 288, rate: 10};
            4'd3: return '{bx0: 250, by0: 110, bx1: 388, by1: 248, rate:  8};
            4'd4: return '{bx0: 280, by0: 140, bx1: 358, by1: 218, rate:  6};
            4'd5: return '{bx0: 300, by0: 160, bx1: 338, by1: 198, rate:  4};
            4'd6: return '{bx0: 310, by0: 170, bx1: 328, by1: 188, rate:  2};
            default: return '{bx0: 20, by0: 20, bx1: 40, by1: 40, rate: 0};
        endcase
    endfunction

endpackage

// File: logic/draw_if.sv
/* rectangle request from scheduler to filler
   corners and colour must hold from start until done */
`timescale 1ns/1ps

interface draw_if;
    import gfx_types_pkg::*;

    logic start;  // one-cycle launch
    coord_t x0;   // top-left
    coord_t y0;
    coord_t x1;   // bottom-right, inclusive
    coord_t y1;
    cidx_t cidx;  // fill colour
    logic done;   // one-cycle, after last pixel

    modport master (
        output start,
        output x0,
        output y0,
        output x1,
        output y1,
        output cidx,
        input  done
    );

    modport slave (
        input  start,
        input  x0,
        input  y0,
        input  x1,
        input  y1,
        input  cidx,
        output done
    );

endinterface

// File: logic/gfx_types_pkg.sv
/* geometry types shared by the scheduler, filler and draw interface
   coordinates are two's complement, negative values lie off-screen */
`include "teleport_settings.svh"

package gfx_types_pkg;

    // screen coordinate, signed
    typedef logic signed [`TP_CORDW-1:0] coord_t;

    // palette index
    typedef logic [`TP_CIDXW-1:0] cidx_t;

    // rectangle filler FSM
    typedef enum logic [1:0] {
        IDLE, // wait for start
        CLIP, // clamp corners to framebuffer
        FILL, // one pixel per free cycle
        DONE  // done pulse
    } fill_state_t;

    // framebuffer limits as coordinates
    localparam coord_t FB_XMAX = coord_t'(`TP_FB_WIDTH - 1);
    localparam coord_t FB_YMAX = coord_t'(`TP_FB_HEIGHT - 1);

    // clamp one coordinate into 0..hi
    function automatic coord_t clamp_coord(coord_t v, coord_t hi);
        if (v < 0) begin
            return '0;
        end else if (v > hi) begin
            return hi;
        end
        return v;
    endfunction

endpackage

// File: logic/rect_fill.sv
/* filled rectangle writer, clips to the framebuffer then scans x fastest
   one write per free cycle, fb_busy stalls the scan, off-screen rectangles give done only */
`timescale 1ns/1ps
`include "teleport_settings.svh"

module rect_fill (
    input  logic clk_100m,
    input  logic rst_n,
    draw_if.slave req,
    input  logic fb_busy,                       // framebuffer stall
    output logic fb_we,
    output gfx_types_pkg::coord_t fb_x,
    output gfx_types_pkg::coord_t fb_y
);
    import gfx_types_pkg::*;

    fill_state_t state;
    coord_t xs;          // clamped left edge, row restart
    coord_t xe;          // clamped right edge
    coord_t ye;          // clamped bottom edge
    logic off_screen;    // nothing to draw

    // rectangle misses the framebuffer or is empty
    assign off_screen = (req.x1 < 0) || (req.y1 < 0) ||
                        (req.x0 > FB_XMAX) || (req.y0 > FB_YMAX) ||
                        (req.x0 > req.x1) || (req.y0 > req.y1);

    assign fb_we = (state == FILL) && !fb_busy;
    assign req.done = (state == DONE);

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            state <= IDLE;
            fb_x <= '0;
            fb_y <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req.start) state <= CLIP;
                end
                CLIP: begin
                    fb_x <= clamp_coord(req.x0, FB_XMAX);
                    fb_y <= clamp_coord(req.y0, FB_YMAX);
                    state <= off_screen ? DONE : FILL;
                end
                FILL: begin
                    if (fb_we) begin
                        if (fb_x == xe) begin
                            if (fb_y == ye) begin
                                state <= DONE; // last pixel written
                            end else begin
                                fb_x <= xs;
                                fb_y <= fb_y + 1'b1;
                            end
                        end else begin
                            fb_x <= fb_x + 1'b1;
                        end
                    end
                end
                default: begin // DONE
                    state <= IDLE;
                end
            endcase
        end
    end

    // scan bounds
    always_ff @(posedge clk_100m) begin
        if (state == CLIP) begin
            xs <= clamp_coord(req.x0, FB_XMAX);
            xe <= clamp_coord(req.x1, FB_XMAX);
            ye <= clamp_coord(req.y1, FB_YMAX);
        end
    end

    a_no_write_busy: assert property (
        @(posedge clk_100m) disable iff (!rst_n)
        fb_busy |-> !fb_we
    ) else $error("write while framebuffer busy");

    a_write_in_fb: assert property (
        @(posedge clk_100m) disable iff (!rst_n)
        fb_we |-> (fb_x >= 0 && fb_x <= FB_XMAX && fb_y >= 0 && fb_y <= FB_YMAX)
    ) else $error("write outside framebuffer");

    // a stalled pixel is presented again unchanged
    a_hold_on_busy: assert property (
        @(posedge clk_100m) disable iff (!rst_n)
        (state == FILL && fb_busy) |=> ($stable(fb_x) && $stable(fb_y))
    ) else $error("position moved during stall");

endmodule

// File: logic/shape_scheduler.sv
/* draws TP_SHAPE_CNT rectangles per accepted frame, one at a time
   frame pulses outside IDLE are dropped, step and offset are sampled once per pass */
`timescale 1ns/1ps
`include "teleport_settings.svh"

module shape_scheduler (
    input  logic clk_100m,
    input  logic rst_n,
    input  logic frame,                         // one-cycle strobe
    input  anim_pkg::anim_step_t anim_step,
    input  gfx_types_pkg::cidx_t colr_offs,
    draw_if.master req,
    output logic pass_done                      // one-cycle strobe
);
    import anim_pkg::*;

    sched_state_t state;
    shape_id_t shape_id;                // current shape
    anim_step_t step_q;                 // step for this pass
    logic [`TP_CIDXW-1:0] colr_q;       // offset for this pass
    shape_geom_t geom;                  // table entry of current shape
    logic signed [`TP_CORDW-1:0] grow;  // rate * step

    always_comb begin
        geom = shape_geom(shape_id);
        grow = geom.rate * `TP_CORDW'(step_q);
    end

    // control path
    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            state <= IDLE;
            shape_id <= '0;
            step_q <= '0;
            colr_q <= '0;
            req.start <= 1'b0;
            pass_done <= 1'b0;
        end else begin
            req.start <= 1'b0;
            pass_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (frame) begin
                        shape_id <= '0;
                        step_q <= anim_step; // hold for whole pass
                        colr_q <= colr_offs;
                        state <= INIT;
                    end
                end
                INIT: begin
                    req.start <= 1'b1; // corners registered on the same edge
                    state <= DRAW;
                end
                DRAW: begin
                    if (req.done) begin
                        if (shape_id == `TP_SHAPE_CNT - 1) begin
                            pass_done <= 1'b1;
                            state <= DONE;
                        end else begin
                            shape_id <= shape_id + 1'b1;
                            state <= INIT;
                        end
                    end
                end
                default: begin // DONE
                    state <= IDLE;
                end
            endcase
        end
    end

    // rectangle payload, loaded in INIT and held through DRAW
    always_ff @(posedge clk_100m) begin
        if (state == INIT) begin
            req.x0 <= geom.bx0 - grow;
            req.y0 <= geom.by0 - grow;
            req.x1 <= geom.bx1 + grow;
            req.y1 <= geom.by1 + grow;
            req.cidx <= colr_q + shape_id; // modulo 16
        end
    end

    a_shape_range: assert property (
        @(posedge clk_100m) disable iff (!rst_n)
        shape_id < `TP_SHAPE_CNT
    ) else $error("shape_id out of range");

    // filler must answer every launch before the next one
    a_one_outstanding: assert property (
        @(posedge clk_100m) disable iff (!rst_n)
        req.start |=> (!req.start throughout req.done [->1])
    ) else $error("second start before done");

endmodule

// File: logic/teleport_draw_top.sv
/* drawing core of the teleport effect, the write port goes to an external framebuffer
   frame must be a single-cycle pulse in the clk_100m domain */
`timescale 1ns/1ps

module teleport_draw_top (
    input  logic clk_100m,
    input  logic rst_n,
    input  logic frame,                     // start of frame
    input  logic fb_busy,                   // framebuffer stall
    output logic fb_we,
    output gfx_types_pkg::coord_t fb_x,
    output gfx_types_pkg::coord_t fb_y,
    output gfx_types_pkg::cidx_t fb_cidx,
    output logic pass_done                  // all shapes drawn
);
    import anim_pkg::*;

    anim_step_t anim_step;
    gfx_types_pkg::cidx_t colr_offs;

    draw_if draw_req ();

    anim_ctrl anim_ctrl_i (
        .clk_100m  (clk_100m),
        .rst_n     (rst_n),
        .frame     (frame),
        .anim_step (anim_step),
        .colr_offs (colr_offs)
    );

    shape_scheduler shape_scheduler_i (
        .clk_100m  (clk_100m),
        .rst_n     (rst_n),
        .frame     (frame),
        .anim_step (anim_step),
        .colr_offs (colr_offs),
        .req       (draw_req.master),
        .pass_done (pass_done)
    );

    rect_fill rect_fill_i (
        .clk_100m (clk_100m),
        .rst_n    (rst_n),
        .req      (draw_req.slave),
        .fb_busy  (fb_busy),
        .fb_we    (fb_we),
        .fb_x     (fb_x),
        .fb_y     (fb_y)
    );

    assign fb_cidx = draw_req.cidx; // colour held for whole rectangle

endmodule

// File: sim/tb_teleport.sv
/* directed testbench for teleport_draw_top acting as its framebuffer
   a full pass takes several hundred thousand cycles and random stalls roughly double it */
`timescale 1ns/1ps
`include "teleport_settings.svh"

module tb_teleport;
    import gfx_types_pkg::*;
    import anim_pkg::*;

    localparam int WAIT_LIMIT = 2000000; // cycles per wait loop
    localparam int SHAPES = `TP_SHAPE_CNT;

    logic clk_100m;
    logic rst_n;
    logic frame;
    logic fb_busy;
    logic fb_we;
    coord_t fb_x;
    coord_t fb_y;
    cidx_t fb_cidx;
    logic pass_done;

    int err_cnt;
    int check_cnt;
    int frames_sent;     // frame pulses since reset
    logic busy_rand;     // random stalls on
    logic [15:0] lfsr;

    int exp_cnt [SHAPES];   // model of each clamped rectangle
    int exp_x0 [SHAPES];
    int exp_y0 [SHAPES];
    int exp_x1 [SHAPES];
    int exp_y1 [SHAPES];
    int exp_cidx [SHAPES];
    int got_cnt [SHAPES];   // seen by the write monitor
    int got_fx [SHAPES];
    int got_fy [SHAPES];
    int got_lx [SHAPES];
    int got_ly [SHAPES];
    int got_cidx [SHAPES];
    int cidx_bad [SHAPES];
    int cur_shape;
    int total_wr;
    int extra_wr;
    int done_cnt;
    int stall_cnt;

    teleport_draw_top teleport_draw_top_i (
        .clk_100m  (clk_100m),
        .rst_n     (rst_n),
        .frame     (frame),
        .fb_busy   (fb_busy),
        .fb_we     (fb_we),
        .fb_x      (fb_x),
        .fb_y      (fb_y),
        .fb_cidx   (fb_cidx),
        .pass_done (pass_done)
    );

    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;
    end

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // base rectangles at step 0 and growth per step
    function automatic shape_geom_t geom_of(input int k);
        case (k)
            0: return '{bx0:  80, by0:   0, bx1: 558, by1: 498, rate: 24};
            1: return '{bx0: 160, by0:  20, bx1: 478, by1: 338, rate: 16};
            2: return '{bx0: 210, by0:  70, bx1: 428, by1: 288, rate: 10};
            3: return '{bx0: 250, by0: 110, bx1: 388, by1: 248, rate:  8};
            4: return '{bx0: 280, by0: 140, bx1: 358, by1: 218, rate:  6};
            5: return '{bx0: 300, by0: 160, bx1: 338, by1: 198, rate:  4};
            default: return '{bx0: 310, by0: 170, bx1: 328, by1: 188, rate: 2};
        endcase
    endfunction

    function automatic int limit_to(input int v, input int hi);
        if (v < 0) return 0;
        if (v > hi) return hi;
        return v;
    endfunction

    // first shape at or after from that draws anything
    function automatic int next_shape(input int from);
        int k;
        k = from;
        while (k < SHAPES && exp_cnt[k] == 0) k++;
        return k;
    endfunction

    task build_model(input int step, input int offs);
        shape_geom_t g;
        int grow;
        int x0;
        int y0;
        int x1;
        int y1;
        for (int k = 0; k < SHAPES; k++) begin
            g = geom_of(k);
            grow = int'(g.rate) * step;
            x0 = int'(g.bx0) - grow;
            y0 = int'(g.by0) - grow;
            x1 = int'(g.bx1) + grow;
            y1 = int'(g.by1) + grow;
            exp_x0[k] = limit_to(x0, `TP_FB_WIDTH - 1);
            exp_y0[k] = limit_to(y0, `TP_FB_HEIGHT - 1);
            exp_x1[k] = limit_to(x1, `TP_FB_WIDTH - 1);
            exp_y1[k] = limit_to(y1, `TP_FB_HEIGHT - 1);
            exp_cidx[k] = (offs + k) % 16;
            if (x1 < 0 || y1 < 0 || x0 > `TP_FB_WIDTH - 1 || y0 > `TP_FB_HEIGHT - 1 ||
                x0 > x1 || y0 > y1) begin
                exp_cnt[k] = 0; // wholly off-screen
            end else begin
                exp_cnt[k] = (exp_x1[k] - exp_x0[k] + 1) * (exp_y1[k] - exp_y0[k] + 1);
            end
        end
    endtask

    task clear_monitor;
        for (int k = 0; k < SHAPES; k++) begin
            got_cnt[k] = 0;
            cidx_bad[k] = 0;
        end
        cur_shape = next_shape(0);
        total_wr = 0;
        extra_wr = 0;
        done_cnt = 0;
        stall_cnt = 0;
    endtask

    // model pixel counts mark where one shape ends
    always @(posedge clk_100m) begin
        if (rst_n) begin
            if ($isunknown({fb_we, pass_done})) begin
                err_cnt++;
                $display("unknown value on fb_we or pass_done at %0t", $time);
            end
            if (fb_busy) stall_cnt++;
            if (pass_done === 1'b1) done_cnt++;
            if (fb_we === 1'b1) begin
                total_wr++;
                if (fb_busy) begin
                    err_cnt++;
                    $display("write issued while fb_busy was high at %0t", $time);
                end
                if (cur_shape >= SHAPES) begin
                    extra_wr++;
                end else begin
                    if (got_cnt[cur_shape] == 0) begin
                        got_fx[cur_shape] = int'(fb_x);
                        got_fy[cur_shape] = int'(fb_y);
                        got_cidx[cur_shape] = int'(fb_cidx);
                    end
                    if (int'(fb_cidx) != got_cidx[cur_shape]) cidx_bad[cur_shape]++;
                    got_lx[cur_shape] = int'(fb_x);
                    got_ly[cur_shape] = int'(fb_y);
                    got_cnt[cur_shape]++;
                    if (got_cnt[cur_shape] == exp_cnt[cur_shape]) begin
                        cur_shape = next_shape(cur_shape + 1);
                    end
                end
            end
        end
    end

    // one LFSR step per cycle drives fb_busy
    always @(negedge clk_100m) begin
        if (busy_rand) begin
            lfsr = lfsr_step(lfsr);
            fb_busy = lfsr[0];
        end else begin
            fb_busy = 1'b0;
        end
    end

    task compare_int(input string what, input int got, input int exp);
        check_cnt++;
        if (got != exp) begin
            err_cnt++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task finish_run;
        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    task reset_dut;
        rst_n = 1'b0;
        frame = 1'b0;
        repeat (3) @(negedge clk_100m);
        rst_n = 1'b1;
        frames_sent = 0;
    endtask

    task pulse_frame;
        @(negedge clk_100m);
        frame = 1'b1;
        frames_sent++;
        @(negedge clk_100m);
        frame = 1'b0;
    endtask

    // extra frame pulses go out every 1000 cycles while the pass runs
    task run_pass(input int extra_frames);
        int step;
        int offs;
        int waited;
        int left;
        step = (frames_sent / `TP_ANIM_SPEED) % `TP_ANIM_CNT;
        offs = (frames_sent / (`TP_ANIM_SPEED * `TP_ANIM_CNT)) % 16;
        $display("pass at step %0d, colour offset %0d, %0d extra frames", step, offs, extra_frames);
        build_model(step, offs);
        clear_monitor();
        pulse_frame();
        waited = 0;
        left = extra_frames;
        while (done_cnt == 0 && waited < WAIT_LIMIT) begin
            @(negedge clk_100m);
            waited++;
            if (left > 0 && waited % 1000 == 0) begin
                frame = 1'b1;
                frames_sent++;
                left--;
            end else begin
                frame = 1'b0;
            end
        end
        frame = 1'b0;
        if (done_cnt == 0) begin
            err_cnt++;
            $display("timeout: no pass_done within %0d cycles", WAIT_LIMIT);
            finish_run();
        end else begin
            repeat (20) @(negedge clk_100m); // a restarted pass would write here
        end
    endtask

    task check_pass;
        for (int k = 0; k < SHAPES; k++) begin
            compare_int($sformatf("shape %0d write count", k), got_cnt[k], exp_cnt[k]);
            if (exp_cnt[k] > 0) begin
                compare_int($sformatf("shape %0d first x", k), got_fx[k], exp_x0[k]);
                compare_int($sformatf("shape %0d first y", k), got_fy[k], exp_y0[k]);
                compare_int($sformatf("shape %0d last x", k), got_lx[k], exp_x1[k]);
                compare_int($sformatf("shape %0d last y", k), got_ly[k], exp_y1[k]);
                compare_int($sformatf("shape %0d colour", k), got_cidx[k], exp_cidx[k]);
                compare_int($sformatf("shape %0d colour changes", k), cidx_bad[k], 0);
            end
        end
        compare_int("writes after last shape", extra_wr, 0);
        compare_int("pass_done pulses", done_cnt, 1);
    endtask

    task idle_after_reset;
        clear_monitor();
        repeat (100) @(negedge clk_100m);
        compare_int("writes without frame", total_wr, 0);
        compare_int("pass_done without frame", done_cnt, 0);
    endtask

    task first_pass;
        run_pass(0);
        check_pass();
    endtask

    // frames 3 and 4 land inside the pass so frame 5 draws at step 1
    task frames_during_pass;
        run_pass(2);
        check_pass();
        run_pass(0);
        check_pass();
    endtask

    // frames 7 to 20 land inside the pass so frame 21 draws at step 0 and offset 1
    task colour_turn;
        run_pass(14);
        check_pass();
        run_pass(0);
        check_pass();
    endtask

    task random_busy_pass;
        busy_rand = 1'b1;
        run_pass(0);
        busy_rand = 1'b0;
        check_pass();
        check_cnt++;
        if (stall_cnt == 0) begin
            err_cnt++;
            $display("random fb_busy was never asserted during the pass");
        end
    endtask

    initial begin
        rst_n = 1'b0;
        frame = 1'b0;
        fb_busy = 1'b0;
        busy_rand = 1'b0;
        lfsr = 16'd64529;
        err_cnt = 0;
        check_cnt = 0;
        frames_sent = 0;
        build_model(0, 0);
        clear_monitor();
        reset_dut();
        idle_after_reset();
        first_pass();
        frames_during_pass();
        colour_turn();
        random_busy_pass();
        finish_run();
    end

endmodule

// File: verilog.f
+incdir+include
logic/gfx_types_pkg.sv
logic/anim_pkg.sv
logic/draw_if.sv
logic/anim_ctrl.sv
logic/shape_scheduler.sv
logic/rect_fill.sv
logic/teleport_draw_top.sv
sim/tb_teleport.sv
